//--- scc_pkg.sv
package scc_pkg;

	localparam int REG_W = 8; // Every SCC register is a byte
	localparam int IDX_W = 4; // Pointer reaches 0 to 15

	typedef logic [REG_W-1:0] reg_byte_t;
	typedef logic [IDX_W-1:0] reg_idx_t;

	// Write register numbers
	localparam reg_idx_t WR0_IDX  = 4'd0;
	localparam reg_idx_t WR1_IDX  = 4'd1;
	localparam reg_idx_t WR2_IDX  = 4'd2;
	localparam reg_idx_t WR9_IDX  = 4'd9;
	localparam reg_idx_t WR15_IDX = 4'd15;

	// Read register numbers
	localparam reg_idx_t RR0_IDX  = 4'd0;
	localparam reg_idx_t RR1_IDX  = 4'd1;
	localparam reg_idx_t RR2_IDX  = 4'd2;
	localparam reg_idx_t RR3_IDX  = 4'd3;
	localparam reg_idx_t RR15_IDX = 4'd15;
	localparam int ALIAS_BIT = 2; // 4..7 fold onto 0..3, 11 onto 15

	// WR0 command field, bits 5..3
	localparam logic [2:0] CMD_POINT_HIGH = 3'b001;
	localparam logic [2:0] CMD_RESET_EXT  = 3'b010;

	// WR9 reset field, bits 7..6
	localparam logic [1:0] RST_CHAN_B = 2'b01;
	localparam logic [1:0] RST_CHAN_A = 2'b10;
	localparam logic [1:0] RST_FULL   = 2'b11;

	localparam reg_byte_t WR15_RESET_VAL = 8'hF8;
	localparam reg_byte_t WR1_KEEP_MASK  = 8'h24; // Bits 5 and 2 survive channel reset
	localparam reg_byte_t RR1_IDLE_VAL   = 8'h07; // All sent, residue 011
	localparam reg_byte_t RR0_BASE_VAL   = 8'h44; // Tx empty, Tx underrun
	localparam reg_byte_t RR15_MASK      = 8'hFA; // Bits 2 and 0 read as zero
	localparam int RR0_DCD_BIT = 3;

	localparam int WR15_DCD_IE_BIT = 3;
	localparam int WR1_EXT_IE_BIT  = 0;
	localparam int WR9_MIE_BIT     = 3; // Master interrupt enable
	localparam int WR9_VIS_BIT     = 4; // Vector includes status

	// Vector status codes
	localparam logic [2:0] VEC_EXT_A = 3'b101;
	localparam logic [2:0] VEC_EXT_B = 3'b001;
	localparam logic [2:0] VEC_NONE  = 3'b011;

	// One decoded register write
	typedef struct packed {
		logic      write;
		logic      chan_a;
		reg_idx_t  idx;
		reg_byte_t data;
	} wr_cmd_t;

	// One-cycle reset pulses
	typedef struct packed {
		logic full;
		logic chan_a;
		logic chan_b;
		logic ext_a;
		logic ext_b;
	} reset_cmd_t;

	// Channel state seen by later stages
	typedef struct packed {
		reg_byte_t wr15;
		logic      dcd_view;
		logic      ext_pending;
		reg_byte_t wr1;
	} chan_status_t;

endpackage

//--- scc_bus_decode.sv
`timescale 1ns/1ps

module scc_bus_decode import scc_pkg::*; (
	input  logic       sysclk,
	input  logic       reset,
	input  logic       cs,
	input  logic       we,
	input  logic [1:0] rs,      // [1] data/ctl, [0] A/B
	input  reg_byte_t  wdata,
	output wr_cmd_t    wr_cmd,
	output reset_cmd_t rst_cmd,
	output reg_idx_t   ptr
);

	logic       ctl_acc;
	logic       ctl_wr;
	logic       wr0_wr;
	logic       wr9_wr;
	logic [1:0] rst_code;
	logic       ext_cmd;
	logic       full_hit;

	assign ctl_acc  = cs & ~rs[1];          // Control port read or write
	assign ctl_wr   = ctl_acc & we;
	assign wr0_wr   = ctl_wr & (ptr == WR0_IDX);
	assign wr9_wr   = ctl_wr & (ptr == WR9_IDX);
	assign rst_code = wdata[7:6];
	assign ext_cmd  = wr0_wr & (wdata[5:3] == CMD_RESET_EXT);
	assign full_hit = wr9_wr & (rst_code == RST_FULL);

	// Register pointer
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			ptr <= '0;
		end else if (ctl_acc) begin
			if (wr0_wr) begin
				ptr <= {wdata[5:3] == CMD_POINT_HIGH, wdata[2:0]}; // Point high adds 8
			end else begin
				ptr <= '0; // Back to WR0 after any other access
			end
		end
	end

	// Write command and reset pulses
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			wr_cmd  <= '0;
			rst_cmd <= '0;
		end else begin
			wr_cmd.write   <= ctl_wr;
			wr_cmd.chan_a  <= rs[0];
			wr_cmd.idx     <= ptr;   // Pointer before this edge
			wr_cmd.data    <= wdata;
			rst_cmd.full   <= full_hit;
			// Full reset also hits both channels
			rst_cmd.chan_a <= full_hit | (wr9_wr & (rst_code == RST_CHAN_A));
			rst_cmd.chan_b <= full_hit | (wr9_wr & (rst_code == RST_CHAN_B));
			rst_cmd.ext_a  <= ext_cmd & rs[0];
			rst_cmd.ext_b  <= ext_cmd & ~rs[0];
		end
	end

endmodule

//--- scc_channel.sv
`timescale 1ns/1ps

module scc_channel import scc_pkg::*; #(
	parameter bit IS_A = 1'b1 // Channel A when set
) (
	input  logic         sysclk,
	input  logic         reset,
	input  wr_cmd_t      wr_cmd,
	input  logic         chan_rst,  // Channel reset, includes full
	input  logic         full_rst,
	input  logic         ext_rst,   // Reset ext/status interrupts
	input  logic         dcd,       // Async pin
	output chan_status_t status
);

	reg_byte_t wr1;
	reg_byte_t wr15;
	logic      dcd_s1;
	logic      dcd_s2;
	logic      dcd_latch;
	logic      latch_open;
	logic      ext_pending;
	logic      wr_hit;
	logic      dcd_ie;
	logic      do_latch;

	assign wr_hit = wr_cmd.write & (wr_cmd.chan_a == IS_A);
	assign dcd_ie = wr15[WR15_DCD_IE_BIT];

	// Close latch on an enabled DCD change
	assign do_latch = latch_open & dcd_ie & (dcd_s2 != dcd_latch);

	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			wr1 <= '0;
		end else if (chan_rst) begin
			wr1 <= wr1 & WR1_KEEP_MASK;
		end else if (wr_hit && wr_cmd.idx == WR1_IDX) begin
			wr1 <= wr_cmd.data;
		end
	end

	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			wr15 <= WR15_RESET_VAL;
		end else if (full_rst) begin
			wr15 <= WR15_RESET_VAL;
		end else if (wr_hit && wr_cmd.idx == WR15_IDX) begin
			wr15 <= wr_cmd.data;
		end
	end

	// Two-flop synchronizer
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			dcd_s1 <= 1'b0;
			dcd_s2 <= 1'b0;
		end else begin
			dcd_s1 <= dcd;
			dcd_s2 <= dcd_s1;
		end
	end

	// Ext/status latch and pending flag
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			latch_open  <= 1'b1;
			dcd_latch   <= 1'b0;
			ext_pending <= 1'b0;
		end else begin
			if (do_latch) dcd_latch <= dcd_s2;
			if (full_rst || ext_rst) begin
				latch_open  <= 1'b1; // Reopen, track live again
				ext_pending <= 1'b0;
			end else if (do_latch) begin
				latch_open <= 1'b0;
				if (wr1[WR1_EXT_IE_BIT]) ext_pending <= 1'b1;
			end
		end
	end

	assign status.wr15        = wr15;
	assign status.dcd_view    = dcd_ie ? dcd_latch : dcd_s2; // Frozen while IE set
	assign status.ext_pending = ext_pending;
	assign status.wr1         = wr1;

endmodule

//--- scc_int_ctrl.sv
`timescale 1ns/1ps

module scc_int_ctrl import scc_pkg::*; (
	input  logic         sysclk,
	input  logic         reset,
	input  wr_cmd_t      wr_cmd,
	input  chan_status_t stat_a,
	input  chan_status_t stat_b,
	output logic         irq_n,
	output logic [2:0]   vec_status,
	output reg_byte_t    wr2,
	output reg_byte_t    wr9
);

	logic [5:0] wr9_q;  // Reset command bits not kept
	logic       any_ip;

	// WR2 vector, shared by both channels
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			wr2 <= '0;
		end else if (wr_cmd.write && wr_cmd.idx == WR2_IDX) begin
			wr2 <= wr_cmd.data;
		end
	end

	// WR9 low bits, hardware reset only
	always_ff @(posedge sysclk or posedge reset) begin
		if (reset) begin
			wr9_q <= '0;
		end else if (wr_cmd.write && wr_cmd.idx == WR9_IDX) begin
			wr9_q <= wr_cmd.data[5:0];
		end
	end

	assign wr9 = {2'b00, wr9_q};

	// A outranks B
	always_comb begin
		if (stat_a.ext_pending) begin
			vec_status = VEC_EXT_A;
		end else if (stat_b.ext_pending) begin
			vec_status = VEC_EXT_B;
		end else begin
			vec_status = VEC_NONE;
		end
	end

	assign any_ip = stat_a.ext_pending | stat_b.ext_pending;
	assign irq_n  = ~(wr9_q[WR9_MIE_BIT] & any_ip); // Open drain style, low active

endmodule

//--- scc_read_mux.sv
`timescale 1ns/1ps

module scc_read_mux import scc_pkg::*; (
	input  reg_idx_t     ptr,
	input  logic [1:0]   rs,
	input  chan_status_t stat_a,
	input  chan_status_t stat_b,
	input  reg_byte_t    wr2,
	input  reg_byte_t    wr9,
	input  logic [2:0]   vec_status,
	output reg_byte_t    rdata
);

	chan_status_t sel;
	reg_idx_t     eff_idx;
	reg_byte_t    rr0;
	reg_byte_t    rr2_b;
	reg_byte_t    rr3_a;

	assign sel = rs[0] ? stat_a : stat_b;

	// Aliases: 4..7 to 0..3, 11 to 15, others land on zero reads
	always_comb begin
		eff_idx = ptr;
		eff_idx[ALIAS_BIT] = ptr[3];
	end

	always_comb begin
		rr0 = RR0_BASE_VAL;
		rr0[RR0_DCD_BIT] = sel.dcd_view;
	end

	// Status low or high, reversed when VIS set
	assign rr2_b = wr9[WR9_VIS_BIT] ?
		{wr2[7], vec_status[0], vec_status[1], vec_status[2], wr2[3:0]} :
		{wr2[7:4], vec_status, wr2[0]};

	assign rr3_a = {4'b0000, stat_a.ext_pending, 2'b00, stat_b.ext_pending};

	always_comb begin
		rdata = '0;
		if (!rs[1]) begin // Data port reads zero
			case (eff_idx)
				RR0_IDX:  rdata = rr0;
				RR1_IDX:  rdata = RR1_IDLE_VAL;
				RR2_IDX:  rdata = rs[0] ? wr2 : rr2_b;
				RR3_IDX:  rdata = rs[0] ? rr3_a : '0; // Chan B reads zero
				RR15_IDX: rdata = sel.wr15 & RR15_MASK;
				default:  rdata = '0;
			endcase
		end
	end

endmodule

//--- scc_top.sv
`timescale 1ns/1ps

module scc_top import scc_pkg::*; (
	input  logic       sysclk,
	input  logic       reset,
	input  logic       cs,
	input  logic       we,
	input  logic [1:0] rs,
	input  reg_byte_t  wdata,
	output reg_byte_t  rdata,
	output logic       irq_n,
	input  logic       dcd_a,  // Mouse quadrature on a Mac
	input  logic       dcd_b
);

	wr_cmd_t      wr_cmd;
	reset_cmd_t   rst_cmd;
	reg_idx_t     ptr;
	chan_status_t stat_a;
	chan_status_t stat_b;
	logic [2:0]   vec_status;
	reg_byte_t    wr2;
	reg_byte_t    wr9;

	scc_bus_decode scc_bus_decode_inst (
		.sysclk(sysclk), .reset(reset), .cs(cs), .we(we), .rs(rs), .wdata(wdata),
		.wr_cmd(wr_cmd), .rst_cmd(rst_cmd), .ptr(ptr)
	);

	scc_channel #(.IS_A(1'b1)) scc_channel_a (
		.sysclk(sysclk), .reset(reset), .wr_cmd(wr_cmd),
		.chan_rst(rst_cmd.chan_a), .full_rst(rst_cmd.full), .ext_rst(rst_cmd.ext_a),
		.dcd(dcd_a), .status(stat_a)
	);

	scc_channel #(.IS_A(1'b0)) scc_channel_b (
		.sysclk(sysclk), .reset(reset), .wr_cmd(wr_cmd),
		.chan_rst(rst_cmd.chan_b), .full_rst(rst_cmd.full), .ext_rst(rst_cmd.ext_b),
		.dcd(dcd_b), .status(stat_b)
	);

	scc_int_ctrl scc_int_ctrl_inst (
		.sysclk(sysclk), .reset(reset), .wr_cmd(wr_cmd), .stat_a(stat_a), .stat_b(stat_b),
		.irq_n(irq_n), .vec_status(vec_status), .wr2(wr2), .wr9(wr9)
	);

	// Combinational read back, pointer before the strobe edge
	scc_read_mux scc_read_mux_inst (
		.ptr(ptr), .rs(rs), .stat_a(stat_a), .stat_b(stat_b), .wr2(wr2), .wr9(wr9),
		.vec_status(vec_status), .rdata(rdata)
	);

endmodule

//--- scc_asserts.sv
`timescale 1ns/1ps

module scc_asserts import scc_pkg::*; (
	input logic       sysclk,
	input logic       reset,
	input logic       irq_n,
	input reg_byte_t  wr9,
	input reset_cmd_t rst_cmd
);

	// No interrupt while held in reset
	irq_idle_in_reset: assert property (@(posedge sysclk) reset |-> irq_n)
		else $error("irq_n low while reset is high");

	irq_needs_mie: assert property (@(posedge sysclk) disable iff (reset)
		!irq_n |-> wr9[WR9_MIE_BIT])
		else $error("irq_n low with master interrupt enable clear");

	// Channel reset and ext reset come from different writes
	rst_a_single: assert property (@(posedge sysclk) disable iff (reset)
		$onehot0({rst_cmd.chan_a, rst_cmd.ext_a}))
		else $error("Two reset pulses at once on channel A");

	rst_b_single: assert property (@(posedge sysclk) disable iff (reset)
		$onehot0({rst_cmd.chan_b, rst_cmd.ext_b}))
		else $error("Two reset pulses at once on channel B");

endmodule

bind scc_top scc_asserts scc_asserts_inst (.sysclk(sysclk), .reset(reset), .irq_n(irq_n),
	.wr9(wr9), .rst_cmd(rst_cmd));

//--- tb_scc.sv
`timescale 1ns/1ps

module tb_scc import scc_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int NUM_TESTS  = 5;
	localparam int ITERS      = 40;

	logic        sysclk;
	logic        reset;
	logic        cs;
	logic        we;
	logic [1:0]  rs;
	reg_byte_t   wdata;
	reg_byte_t   rdata;
	logic        irq_n;
	logic        dcd_a;
	logic        dcd_b;
	integer      seed;
	int          errors;
	int          checks;
	int          tests_run;
	int          base;
	logic [31:0] r;
	reg_byte_t   got;

	// Reference model with index 1 as channel A like rs[0]
	reg_byte_t m_wr1 [2];
	reg_byte_t m_wr15 [2];
	logic      m_open [2];
	logic      m_latch [2];
	logic      m_pend [2];
	logic      m_dcd [2];  // Pin level as driven
	reg_byte_t m_wr2;
	reg_byte_t m_wr9;

	scc_top scc_top_inst (.sysclk(sysclk), .reset(reset), .cs(cs), .we(we), .rs(rs),
		.wdata(wdata), .rdata(rdata), .irq_n(irq_n), .dcd_a(dcd_a), .dcd_b(dcd_b));

	always #(CLK_PERIOD / 2) sysclk = ~sysclk;

	function automatic reg_byte_t exp_read(input logic ch, input reg_idx_t idx);
		reg_byte_t  v;
		logic [2:0] vec;
		vec = m_pend[1] ? VEC_EXT_A : (m_pend[0] ? VEC_EXT_B : VEC_NONE); // A first
		v = 8'h00;
		case (idx)
			4'd0, 4'd4: begin
				v = 8'h44;
				v[3] = m_wr15[ch][WR15_DCD_IE_BIT] ? m_latch[ch] : m_dcd[ch];
			end
			4'd1, 4'd5: v = 8'h07;
			4'd2, 4'd6: begin
				v = m_wr2;
				if (!ch && m_wr9[WR9_VIS_BIT]) v[6:4] = {vec[0], vec[1], vec[2]};
				else if (!ch) v[3:1] = vec;
			end
			4'd3, 4'd7: if (ch) v = {4'b0000, m_pend[1], 2'b00, m_pend[0]};
			4'd11, 4'd15: v = m_wr15[ch] & 8'hFA;
			default: v = 8'h00;
		endcase
		return v;
	endfunction

	// Enabled DCD change while open closes the latch
	task automatic model_eval(input logic ch);
		if (m_open[ch] && m_wr15[ch][WR15_DCD_IE_BIT] && m_dcd[ch] != m_latch[ch]) begin
			m_open[ch]  = 1'b0;
			m_latch[ch] = m_dcd[ch];
			if (m_wr1[ch][WR1_EXT_IE_BIT]) m_pend[ch] = 1'b1;
		end
	endtask

	task automatic model_write(input logic ch, input reg_idx_t idx, input reg_byte_t d);
		case (idx)
			4'd0: if (d[5:3] == CMD_RESET_EXT) begin
				m_open[ch] = 1'b1;
				m_pend[ch] = 1'b0;
			end
			4'd1: m_wr1[ch] = d;
			4'd2: m_wr2 = d;
			4'd9: begin
				m_wr9 = {2'b00, d[5:0]};
				if (d[7]) m_wr1[1] = m_wr1[1] & 8'h24; // Codes 10 and 11
				if (d[6]) m_wr1[0] = m_wr1[0] & 8'h24; // Codes 01 and 11
				for (int c = 0; c < 2; c++) begin
					if (d[7:6] == 2'b11) begin
						m_wr15[c] = 8'hF8;
						m_open[c] = 1'b1;
						m_pend[c] = 1'b0;
					end
				end
			end
			4'd15: m_wr15[ch] = d;
			default: ;
		endcase
		model_eval(1'b1);
		model_eval(1'b0);
	endtask

	// One strobe entered and left on a falling edge
	task automatic bus_cycle(input logic wr, input logic [1:0] port, input reg_byte_t d,
		output reg_byte_t q);
		cs = 1'b1;
		we = wr;
		rs = port;
		wdata = d;
		#1 q = rdata; // Settled read data from the pointer before the edge
		@(negedge sysclk);
		cs = 1'b0;
		we = 1'b0;
	endtask

	task automatic write_reg(input logic ch, input reg_idx_t idx, input reg_byte_t d);
		reg_byte_t q;
		bus_cycle(1'b1, {1'b0, ch}, {2'b00, idx[3] ? CMD_POINT_HIGH : 3'b000, idx[2:0]}, q);
		bus_cycle(1'b1, {1'b0, ch}, d, q);
		repeat (2) @(negedge sysclk);
		model_write(ch, idx, d);
	endtask

	task automatic report_mismatch(input string what, input reg_byte_t g, input reg_byte_t e);
		$display("FAILED at %0t ns: %s read %h, expected %h", $time, what, g, e);
		errors++;
	endtask

	task automatic read_check(input logic ch, input reg_idx_t idx);
		reg_byte_t q;
		reg_byte_t e;
		bus_cycle(1'b1, {1'b0, ch}, {2'b00, idx[3] ? CMD_POINT_HIGH : 3'b000, idx[2:0]}, q);
		bus_cycle(1'b0, {1'b0, ch}, 8'h00, q);
		e = exp_read(ch, idx);
		checks++;
		if (q !== e) report_mismatch($sformatf("RR%0d channel %s", idx, ch ? "A" : "B"), q, e);
	endtask

	task automatic check_irq();
		logic e;
		e = !(m_wr9[WR9_MIE_BIT] && (m_pend[0] || m_pend[1]));
		checks++;
		if (irq_n !== e) report_mismatch("irq_n", {7'b0, irq_n}, {7'b0, e});
	endtask

	// Synchronizer plus latch update fits in four cycles
	task automatic set_dcd(input logic a, input logic b);
		dcd_a = a;
		dcd_b = b;
		m_dcd[1] = a;
		m_dcd[0] = b;
		repeat (4) @(negedge sysclk);
		model_eval(1'b1);
		model_eval(1'b0);
	endtask

	task automatic test_done(input string name);
		tests_run++;
		$display("Test %0d %s finished with %0d errors", tests_run, name, errors - base);
		base = errors;
	endtask

	// Budget of 40 cycles per iteration
	initial begin
		#(NUM_TESTS * ITERS * 40 * CLK_PERIOD);
		$display("Simulation timed out before all tests finished");
		$display("Regression failed");
		$finish;
	end

	initial begin
		seed = 32'hf4ee_3a4b;
		sysclk = 1'b0;
		reset = 1'b1;
		cs = 1'b0;
		we = 1'b0;
		rs = 2'b00;
		wdata = 8'h00;
		dcd_a = 1'b0;
		dcd_b = 1'b0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		base = 0;
		m_wr2 = 8'h00;
		m_wr9 = 8'h00;
		for (int c = 0; c < 2; c++) begin
			m_wr1[c] = 8'h00;
			m_wr15[c] = 8'hF8; // Hardware reset value
			m_open[c] = 1'b1;
			m_latch[c] = 1'b0;
			m_pend[c] = 1'b0;
			m_dcd[c] = 1'b0;
		end
		repeat (4) @(negedge sysclk);
		reset = 1'b0;

		for (int i = 0; i < ITERS; i++) begin
			r = $random(seed);
			write_reg(r[24], WR2_IDX, r[7:0]);
			write_reg(1'b1, WR15_IDX, r[15:8]);
			write_reg(1'b0, WR15_IDX, r[23:16]);
			read_check(1'b1, RR2_IDX);
			read_check(1'b1, RR15_IDX);
			read_check(1'b0, RR15_IDX);
			read_check(r[25], {2'b01, r[27:26]}); // Alias 4 to 7
			read_check(r[25], 4'd11);
			read_check(r[28], r[31:28]);          // Any index including zero reads
		end
		test_done("register round trip");

		for (int i = 0; i < ITERS; i++) begin
			r = $random(seed);
			write_reg(r[2], r[1] ? WR15_IDX : (r[0] ? WR2_IDX : WR1_IDX), r[15:8]);
			bus_cycle(1'b0, {1'b0, r[3]}, 8'h00, got); // No WR0 write first
			checks++;
			if (got !== exp_read(r[3], RR0_IDX)) report_mismatch("RR0 after access", got,
				exp_read(r[3], RR0_IDX));
			read_check(r[4], RR15_IDX);
			bus_cycle(r[5], {1'b1, r[6]}, r[23:16], got); // Data port
			checks++;
			if (got !== 8'h00) report_mismatch("data port", got, 8'h00);
		end
		test_done("pointer");

		for (int i = 0; i < ITERS; i++) begin
			r = $random(seed);
			write_reg(1'b1, WR1_IDX, r[7:0]);
			write_reg(1'b0, WR1_IDX, r[15:8]);
			write_reg(1'b1, WR15_IDX, r[23:16]);
			write_reg(1'b0, WR15_IDX, r[31:24]);
			r = $random(seed);
			write_reg(r[8], WR9_IDX, r[7:0]);
			checks += 2;
			if (scc_top_inst.scc_channel_a.wr1 !== m_wr1[1])
				report_mismatch("WR1 A", scc_top_inst.scc_channel_a.wr1, m_wr1[1]);
			if (scc_top_inst.scc_channel_b.wr1 !== m_wr1[0])
				report_mismatch("WR1 B", scc_top_inst.scc_channel_b.wr1, m_wr1[0]);
			read_check(1'b1, RR15_IDX);
			read_check(1'b0, RR15_IDX);
		end
		test_done("resets");

		for (int i = 0; i < ITERS; i++) begin
			r = $random(seed);
			write_reg(1'b1, WR15_IDX, r[7:0]);
			write_reg(1'b1, WR1_IDX, r[15:8]);
			write_reg(1'b0, WR15_IDX, r[23:16]);
			write_reg(1'b0, WR1_IDX, r[31:24]);
			r = $random(seed);
			set_dcd(r[0], r[1]);
			read_check(1'b1, RR0_IDX);
			read_check(1'b0, RR0_IDX);
			read_check(1'b1, RR3_IDX);
			if (r[2]) begin
				write_reg(r[3], WR0_IDX, {2'b00, CMD_RESET_EXT, 3'b000});
				read_check(1'b1, RR3_IDX);
				read_check(r[3], RR0_IDX);
			end
		end
		test_done("DCD latch");

		for (int i = 0; i < ITERS; i++) begin
			r = $random(seed);
			write_reg(1'b1, WR15_IDX, r[7:0] | 8'h08);  // DCD IE on so toggles latch
			write_reg(1'b0, WR15_IDX, r[15:8] | 8'h08);
			r = $random(seed);
			write_reg(r[8], WR9_IDX, {2'b00, r[5:0]}); // MIE and VIS
			write_reg(1'b1, WR1_IDX, r[15:8]);
			write_reg(1'b0, WR1_IDX, r[23:16]);
			set_dcd(r[24], r[25]);
			check_irq();
			read_check(1'b0, RR2_IDX);
			if (r[26]) begin
				write_reg(r[27], WR0_IDX, {2'b00, CMD_RESET_EXT, 3'b000});
				check_irq();
				read_check(1'b0, RR2_IDX);
			end
		end
		test_done("interrupt and vector");

		$display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) $display("Regression passed");
		else $display("Regression failed");
		$finish;
	end

endmodule

//--- scc.f
scc_pkg.sv
scc_bus_decode.sv
scc_channel.sv
scc_int_ctrl.sv
scc_read_mux.sv
scc_top.sv
scc_asserts.sv
tb_scc.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_scc
LOG       ?= sim.log
FLIST     ?= scc.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
